// ==== Bender.yml ====
package:
  name: xcvr_mgmt

sources:
  - verilog/xcvr_mgmt_pkg.sv
  - verilog/status_sync.sv
  - verilog/reset_sequencer.sv
  - verilog/csr_common.sv
  - verilog/csr_pcs.sv
  - verilog/lane_datapath.sv
  - verilog/xcvr_mgmt_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/xcvr_mgmt_props.sv
      - bench/tb_xcvr_mgmt.sv

// ==== bench/tb_clock.sv ====
// --------------------------------------
// testbench clock and reset, 4 ns period
// rst_n low for the first 2 rising edges, released on a falling edge
// --------------------------------------

`timescale 1ns/1ps

module tb_clock (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;   // off the sampling edge
   end

endmodule

// ==== bench/tb_xcvr_mgmt.sv ====
// --------------------------------------
// testbench for the transceiver management top
// phy model locks pll and cdr a few cycles after their resets drop
// inputs driven and outputs sampled on the falling edge
// --------------------------------------

`timescale 1ns/1ps

module tb_xcvr_mgmt;

   localparam int READY_LIMIT = 200;   // full reset sequence, cycles
   localparam int DROP_LIMIT  = 20;
   localparam int DATA_ROUNDS = 12;

   logic                              mgmt_clk;
   logic                              rst_n;
   logic [xcvr_mgmt_pkg::ADDR_W-1:0]  mgmt_address;
   logic                              mgmt_read;
   logic                              mgmt_write;
   logic [xcvr_mgmt_pkg::DATA_W-1:0]  mgmt_writedata;
   logic [xcvr_mgmt_pkg::DATA_W-1:0]  mgmt_readdata;
   xcvr_mgmt_pkg::pll_status_t        pll_status;
   xcvr_mgmt_pkg::lane_status_t       lane_status;
   xcvr_mgmt_pkg::phy_reset_t         phy_reset;
   logic                              tx_ready;
   logic                              rx_ready;
   xcvr_mgmt_pkg::lane_data_t         tx_parallel_data;
   xcvr_mgmt_pkg::lane_data_t         phy_tx_data;
   xcvr_mgmt_pkg::lane_data_t         phy_rx_data;
   xcvr_mgmt_pkg::lane_data_t         rx_parallel_data;

   logic        pll_kill;   // holds the phy pll out of lock
   int          lock_cnt;
   logic [31:0] rng;
   logic        timed_out;  // a wait ran out, rest of the run skipped
   int          test_errors;
   int          total_errors;
   int          tests_run;
   int unsigned props_seen;   // assertion failures already counted

   tb_clock clock_gen (.clk(mgmt_clk), .rst_n(rst_n));

   xcvr_mgmt_top uut (.*);

   // --------------------------------------
   // phy model
   // --------------------------------------
   always @(negedge mgmt_clk) begin
      if (phy_reset.pll_powerdown || pll_kill) begin
         lock_cnt              <= 0;
         pll_status.pll_locked <= 1'b0;
      end else if (lock_cnt == 3) begin
         pll_status.pll_locked <= 1'b1;   // few cycles after power-up
      end else begin
         lock_cnt <= lock_cnt + 1;
      end
      lane_status.lockedtodata <= phy_reset.rx_analogreset ? '0 : '1;   // cdr
   end

   // --------------------------------------
   // helpers
   // --------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic random_lanes(output xcvr_mgmt_pkg::lane_data_t w);
      logic [31:0] hi;
      rng = xorshift32(rng);
      hi  = rng;
      rng = xorshift32(rng);
      w   = {hi, rng};
   endtask

   // all ones XOR on each lane whose mask bit is set
   function automatic xcvr_mgmt_pkg::lane_data_t invert_lanes(
      input xcvr_mgmt_pkg::lane_data_t d, input xcvr_mgmt_pkg::lane_mask_t m);
      xcvr_mgmt_pkg::lane_data_t r;
      for (int i = 0; i < xcvr_mgmt_pkg::LANES; i++)
         r[i] = m[i] ? ~d[i] : d[i];
      return r;
   endfunction

   function automatic logic [2:0] status_bits();
      return {phy_reset.pll_powerdown, tx_ready, rx_ready};
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (actual === expected)
      else begin
         test_errors++;
         $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic end_test(input string name);
      int unsigned props_now;
      props_now    = uut.props.fail_count;
      test_errors += int'(props_now - props_seen);
      props_seen   = props_now;
      $display("%s: %0d errors", name, test_errors);
      total_errors += test_errors;
      tests_run++;
      test_errors = 0;
   endtask

   task automatic finish_run();
      total_errors += test_errors + int'(uut.props.fail_count - props_seen);
      $display("%0d tests, %0d errors", tests_run, total_errors);
      if (total_errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   endtask

   // wait on the falling edge until the masked status matches
   task automatic wait_status(input logic [2:0] mask, input logic [2:0] want,
                              input int limit, input string what);
      int n;
      n = 0;
      while (((status_bits() & mask) !== want) && n < limit) begin
         @(negedge mgmt_clk);
         n++;
      end
      if ((status_bits() & mask) !== want) begin
         $display("timeout: %s did not happen within %0d cycles", what, limit);
         test_errors++;
         timed_out = 1'b1;
      end
   endtask

   // --------------------------------------
   // mgmt bus, no waitrequest
   // --------------------------------------
   task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
      @(negedge mgmt_clk);
      mgmt_address   = addr;
      mgmt_writedata = data;
      mgmt_write     = 1'b1;
      @(negedge mgmt_clk);
      mgmt_write     = 1'b0;
   endtask

   task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
      @(negedge mgmt_clk);
      mgmt_address = addr;
      mgmt_read    = 1'b1;
      @(negedge mgmt_clk);
      mgmt_read    = 1'b0;
      data         = mgmt_readdata;   // registered on the edge just passed
   endtask

   task automatic check_read(input logic [7:0] addr, input logic [31:0] expected);
      logic [31:0] rd;
      bus_read(addr, rd);
      check_value($sformatf("read 0x%h", addr), expected, rd);
   endtask

   task automatic check_readback(input logic [7:0] addr);
      logic [31:0] rd;
      rng = xorshift32(rng);
      bus_write(addr, rng);
      bus_read(addr, rd);
      check_value($sformatf("readback 0x%h", addr), {28'd0, rng[3:0]}, rd);
   endtask

   // --------------------------------------
   // tests
   // --------------------------------------
   task automatic test_registers();
      logic [31:0] lane_exp;
      check_readback(xcvr_mgmt_pkg::ADDR_LOOPBACK);
      check_readback(xcvr_mgmt_pkg::ADDR_TX_INVPOL);
      check_readback(xcvr_mgmt_pkg::ADDR_RX_INVPOL);
      lane_exp  = {23'd0, pll_status.pll_locked, lane_status.signaldetect,
                   lane_status.lockedtodata};
      check_read(xcvr_mgmt_pkg::ADDR_LANE_STATUS, lane_exp);
      // settled, both ready and no reset held
      check_read(xcvr_mgmt_pkg::ADDR_RESET_STATUS, 32'h0000_0003);
      check_read(8'h05, 32'hFFFF_FFFF);   // unmapped
      check_read(8'h7F, 32'hFFFF_FFFF);
      check_read(xcvr_mgmt_pkg::ADDR_RESET_CMD, 32'h0);
   endtask

   task automatic test_normal_rx();
      xcvr_mgmt_pkg::lane_mask_t rx_mask;
      xcvr_mgmt_pkg::lane_data_t prev_rx;
      rng     = xorshift32(rng);
      rx_mask = rng[3:0];
      bus_write(xcvr_mgmt_pkg::ADDR_LOOPBACK, 32'h0);
      bus_write(xcvr_mgmt_pkg::ADDR_RX_INVPOL, {28'd0, rx_mask});
      for (int n = 0; n < DATA_ROUNDS; n++) begin
         @(negedge mgmt_clk);
         if (n > 0)
            check_value("rx data", invert_lanes(prev_rx, rx_mask), rx_parallel_data);
         random_lanes(phy_rx_data);
         prev_rx = phy_rx_data;
      end
   endtask

   task automatic test_loopback();
      xcvr_mgmt_pkg::lane_mask_t lpbk;
      xcvr_mgmt_pkg::lane_mask_t tx_mask;
      xcvr_mgmt_pkg::lane_mask_t rx_mask;
      xcvr_mgmt_pkg::lane_data_t tx1;   // tx word one cycle back
      xcvr_mgmt_pkg::lane_data_t tx2;   // two cycles back
      xcvr_mgmt_pkg::lane_data_t rx1;
      xcvr_mgmt_pkg::lane_data_t looped;
      xcvr_mgmt_pkg::lane_data_t direct;
      xcvr_mgmt_pkg::lane_data_t exp_rx;
      lpbk    = 4'b0101;   // lanes 0 and 2 looped
      rng     = xorshift32(rng);
      tx_mask = rng[3:0];
      rx_mask = rng[7:4];
      bus_write(xcvr_mgmt_pkg::ADDR_LOOPBACK, {28'd0, lpbk});
      bus_write(xcvr_mgmt_pkg::ADDR_TX_INVPOL, {28'd0, tx_mask});
      bus_write(xcvr_mgmt_pkg::ADDR_RX_INVPOL, {28'd0, rx_mask});
      for (int n = 0; n < DATA_ROUNDS; n++) begin
         @(negedge mgmt_clk);
         if (n > 0)
            check_value("tx data", invert_lanes(tx1, tx_mask), phy_tx_data);
         if (n > 1) begin
            looped = invert_lanes(invert_lanes(tx2, tx_mask), rx_mask);
            direct = invert_lanes(rx1, rx_mask);
            for (int i = 0; i < xcvr_mgmt_pkg::LANES; i++)
               exp_rx[i] = lpbk[i] ? looped[i] : direct[i];
            check_value("loopback rx data", exp_rx, rx_parallel_data);
         end
         tx2 = tx1;
         random_lanes(tx_parallel_data);
         random_lanes(phy_rx_data);
         tx1 = tx_parallel_data;
         rx1 = phy_rx_data;
      end
   endtask

   task automatic test_rx_reset();
      bus_write(xcvr_mgmt_pkg::ADDR_RESET_CMD, 32'h4);   // reset_rx_digital
      wait_status(3'b001, 3'b000, DROP_LIMIT, "rx_ready drop after rx digital reset");
      if (!timed_out) begin
         check_value("tx_ready during rx reset", 64'd1, tx_ready);
         wait_status(3'b011, 3'b011, READY_LIMIT, "rx_ready return after rx digital reset");
      end
   endtask

   task automatic test_pll_loss();
      @(negedge mgmt_clk);
      pll_kill = 1'b1;
      // both ready low, pll back in power-down
      wait_status(3'b111, 3'b100, DROP_LIMIT, "power-down after pll lock loss");
      if (!timed_out) begin
         pll_kill = 1'b0;
         wait_status(3'b011, 3'b011, READY_LIMIT, "ready outputs after pll relock");
      end
   endtask

   // --------------------------------------
   // main sequence
   // --------------------------------------
   initial begin
      mgmt_address     = '0;
      mgmt_read        = 1'b0;
      mgmt_write       = 1'b0;
      mgmt_writedata   = '0;
      tx_parallel_data = '0;
      phy_rx_data      = '0;
      pll_status       <= '0;   // rx_oc_busy stays low
      lane_status      <= '{lockedtodata: 4'b0000, signaldetect: 4'b1011};
      pll_kill         = 1'b0;
      lock_cnt         <= 0;
      rng              = 32'h9e482a2d;
      timed_out        = 1'b0;
      test_errors      = 0;
      total_errors     = 0;
      tests_run        = 0;
      props_seen       = 0;

      wait_status(3'b011, 3'b011, READY_LIMIT, "tx_ready and rx_ready after reset");
      end_test("reset sequence");
      if (!timed_out) begin
         test_registers();
         end_test("register map");
         test_normal_rx();
         end_test("normal rx path");
         test_loopback();
         end_test("serial loopback");
         test_rx_reset();
         end_test("rx digital reset");
      end
      if (!timed_out) begin
         test_pll_loss();
         end_test("pll lock loss");
      end
      finish_run();
   end

endmodule

// ==== bench/xcvr_mgmt_props.sv ====
// --------------------------------------
// reset ordering checks, bound into xcvr_mgmt_top
// fail_count lets the testbench total the assertion failures
// --------------------------------------

`timescale 1ns/1ps

module xcvr_mgmt_props (
   input logic                       mgmt_clk,
   input logic                       rst_n,
   input xcvr_mgmt_pkg::phy_reset_t  phy_reset,
   input logic                       tx_ready,
   input logic                       rx_ready
);

   int unsigned fail_count = 0;

   // reset state one cycle into rst_n
   reset_state: assert property (@(posedge mgmt_clk)
      !rst_n |=> (phy_reset == 4'b1111 && !tx_ready && !rx_ready))
   else begin
      fail_count++;
      $error("phy resets or ready outputs wrong after reset");
   end

   // tx side must be fully out of reset
   tx_ready_order: assert property (@(posedge mgmt_clk) disable iff (!rst_n)
      tx_ready |-> (!phy_reset.pll_powerdown && !phy_reset.tx_digitalreset))
   else begin
      fail_count++;
      $error("tx_ready high while pll or tx digital reset active");
   end

   rx_ready_order: assert property (@(posedge mgmt_clk) disable iff (!rst_n)
      rx_ready |-> (!phy_reset.rx_analogreset && !phy_reset.rx_digitalreset))
   else begin
      fail_count++;
      $error("rx_ready high while rx analog or digital reset active");
   end

   // rx analog stays in reset while the pll is powered down
   pd_holds_rx: assert property (@(posedge mgmt_clk) disable iff (!rst_n)
      phy_reset.pll_powerdown |-> phy_reset.rx_analogreset)
   else begin
      fail_count++;
      $error("rx analog reset released during pll power-down");
   end

endmodule

bind xcvr_mgmt_top xcvr_mgmt_props props (
   .mgmt_clk, .rst_n, .phy_reset, .tx_ready, .rx_ready);

// ==== project.f ====
verilog/xcvr_mgmt_pkg.sv
verilog/status_sync.sv
verilog/reset_sequencer.sv
verilog/csr_common.sv
verilog/csr_pcs.sv
verilog/lane_datapath.sv
verilog/xcvr_mgmt_top.sv
bench/tb_clock.sv
bench/xcvr_mgmt_props.sv
bench/tb_xcvr_mgmt.sv

// ==== verilog/csr_common.sv ====
// --------------------------------------
// common csr block, addresses 0x10 to 0x13
// unowned addresses read all ones, the top ANDs both blocks
// reset commands leave as one-cycle pulses a cycle after the write
// --------------------------------------

`timescale 1ns/1ps

module csr_common (
   input  logic                                  mgmt_clk,
   input  logic                                  rst_n,
   input  logic [xcvr_mgmt_pkg::ADDR_W-1:0]      mgmt_address,
   input  logic                                  mgmt_read,
   input  logic                                  mgmt_write,
   input  logic [xcvr_mgmt_pkg::DATA_W-1:0]      mgmt_writedata,
   output logic [xcvr_mgmt_pkg::DATA_W-1:0]      readdata,
   input  xcvr_mgmt_pkg::pll_status_t            pll_status,
   input  xcvr_mgmt_pkg::lane_status_t           lane_status,
   input  xcvr_mgmt_pkg::phy_reset_t             phy_reset,
   input  logic                                  tx_ready,
   input  logic                                  rx_ready,
   output xcvr_mgmt_pkg::reset_cmd_t             reset_cmd,
   output xcvr_mgmt_pkg::lane_mask_t             loopback
);

   localparam int L = xcvr_mgmt_pkg::LANES;

   logic [xcvr_mgmt_pkg::DATA_W-1:0] rd_mux;
   logic                             wr_cmd;
   logic                             wr_lpbk;

   assign wr_cmd  = mgmt_write && (mgmt_address == xcvr_mgmt_pkg::ADDR_RESET_CMD);
   assign wr_lpbk = mgmt_write && (mgmt_address == xcvr_mgmt_pkg::ADDR_LOOPBACK);

   // --------------------------------------
   // read mux
   // --------------------------------------
   always_comb begin
      rd_mux = '1;   // not ours
      unique case (mgmt_address)
         xcvr_mgmt_pkg::ADDR_LANE_STATUS: begin
            rd_mux            = '0;
            rd_mux[L-1:0]     = lane_status.lockedtodata;
            rd_mux[2*L-1:L]   = lane_status.signaldetect;
            rd_mux[2*L]       = pll_status.pll_locked;
         end
         xcvr_mgmt_pkg::ADDR_RESET_STATUS: begin
            rd_mux    = '0;
            rd_mux[0] = tx_ready;
            rd_mux[1] = rx_ready;
            rd_mux[2] = phy_reset.pll_powerdown;
            rd_mux[3] = phy_reset.tx_digitalreset;
            rd_mux[4] = phy_reset.rx_analogreset;
            rd_mux[5] = phy_reset.rx_digitalreset;
         end
         xcvr_mgmt_pkg::ADDR_RESET_CMD: rd_mux = '0;   // write-only
         xcvr_mgmt_pkg::ADDR_LOOPBACK: begin
            rd_mux        = '0;
            rd_mux[L-1:0] = loopback;
         end
         default: ;
      endcase
   end

   always_ff @(posedge mgmt_clk) begin
      if (!rst_n) begin
         readdata  <= '0;
         loopback  <= '0;
         reset_cmd <= '0;
      end else begin
         if (mgmt_read) readdata <= rd_mux;   // else hold
         if (wr_lpbk) loopback <= mgmt_writedata[L-1:0];
         reset_cmd <= '0;   // pulses clear themselves
         if (wr_cmd) begin
            reset_cmd.reset_all        <= mgmt_writedata[0];
            reset_cmd.reset_tx_digital <= mgmt_writedata[1];
            reset_cmd.reset_rx_digital <= mgmt_writedata[2];
         end
      end
   end

endmodule

// ==== verilog/csr_pcs.sv ====
// --------------------------------------
// pcs csr block, polarity inversion at 0x20 and 0x21
// unowned addresses read all ones
// --------------------------------------

`timescale 1ns/1ps

module csr_pcs (
   input  logic                              mgmt_clk,
   input  logic                              rst_n,
   input  logic [xcvr_mgmt_pkg::ADDR_W-1:0]  mgmt_address,
   input  logic                              mgmt_read,
   input  logic                              mgmt_write,
   input  logic [xcvr_mgmt_pkg::DATA_W-1:0]  mgmt_writedata,
   output logic [xcvr_mgmt_pkg::DATA_W-1:0]  readdata,
   output xcvr_mgmt_pkg::lane_mask_t         tx_invpol,
   output xcvr_mgmt_pkg::lane_mask_t         rx_invpol
);

   localparam int L = xcvr_mgmt_pkg::LANES;

   logic [xcvr_mgmt_pkg::DATA_W-1:0] rd_mux;

   always_comb begin
      rd_mux = '1;
      unique case (mgmt_address)
         xcvr_mgmt_pkg::ADDR_TX_INVPOL: rd_mux = {{(xcvr_mgmt_pkg::DATA_W-L){1'b0}}, tx_invpol};
         xcvr_mgmt_pkg::ADDR_RX_INVPOL: rd_mux = {{(xcvr_mgmt_pkg::DATA_W-L){1'b0}}, rx_invpol};
         default: ;   // leave all ones for the AND
      endcase
   end

   always_ff @(posedge mgmt_clk) begin
      if (!rst_n) begin
         readdata  <= '0;
         tx_invpol <= '0;
         rx_invpol <= '0;
      end else begin
         if (mgmt_read) readdata <= rd_mux;
         if (mgmt_write && mgmt_address == xcvr_mgmt_pkg::ADDR_TX_INVPOL)
            tx_invpol <= mgmt_writedata[L-1:0];   // upper bits dropped
         if (mgmt_write && mgmt_address == xcvr_mgmt_pkg::ADDR_RX_INVPOL)
            rx_invpol <= mgmt_writedata[L-1:0];
      end
   end

endmodule

// ==== verilog/lane_datapath.sv ====
// --------------------------------------
// per-lane polarity inversion and serial loopback
// tx path 1 cycle, rx path 1 cycle, loopback tx to rx 2 cycles
// loopback taps the registered tx word
// --------------------------------------

`timescale 1ns/1ps

module lane_datapath (
   input  logic                       mgmt_clk,
   input  logic                       rst_n,
   input  xcvr_mgmt_pkg::lane_ctrl_t  lane_ctrl,
   input  xcvr_mgmt_pkg::lane_data_t  tx_parallel_data,
   output xcvr_mgmt_pkg::lane_data_t  phy_tx_data,
   input  xcvr_mgmt_pkg::lane_data_t  phy_rx_data,
   output xcvr_mgmt_pkg::lane_data_t  rx_parallel_data
);

   localparam int W = xcvr_mgmt_pkg::LANE_W;

   always_ff @(posedge mgmt_clk) begin
      if (!rst_n) begin
         phy_tx_data      <= '0;
         rx_parallel_data <= '0;
      end else begin
         for (int i = 0; i < xcvr_mgmt_pkg::LANES; i++) begin
            phy_tx_data[i] <= tx_parallel_data[i] ^ {W{lane_ctrl.tx_invpol[i]}};
            // loopback or phy word, then rx inversion
            rx_parallel_data[i] <= (lane_ctrl.loopback[i] ? phy_tx_data[i] : phy_rx_data[i])
                                   ^ {W{lane_ctrl.rx_invpol[i]}};
         end
      end
   end

endmodule

// ==== verilog/reset_sequencer.sv ====
// --------------------------------------
// ordered phy reset release on mgmt_clk
// inputs must already be synchronized
// all lanes share one reset of each kind
// --------------------------------------

`timescale 1ns/1ps

module reset_sequencer (
   input  logic                        mgmt_clk,
   input  logic                        rst_n,
   input  xcvr_mgmt_pkg::pll_status_t  pll_status,
   input  xcvr_mgmt_pkg::lane_mask_t   lockedtodata,
   input  xcvr_mgmt_pkg::reset_cmd_t   reset_cmd,
   output xcvr_mgmt_pkg::phy_reset_t   phy_reset,
   output logic                        tx_ready,
   output logic                        rx_ready
);

   typedef enum logic [1:0] {TX_PD, TX_LOCK, TX_REL, TX_READY} tx_state_t;
   typedef enum logic [1:0] {RX_ANALOG, RX_LTD, RX_READY} rx_state_t;

   tx_state_t tx_state;
   rx_state_t rx_state;
   logic [xcvr_mgmt_pkg::PD_CNT_W-1:0]  pd_cnt;    // power-down hold
   logic [xcvr_mgmt_pkg::LTD_CNT_W-1:0] ltd_cnt;   // lock stability
   logic pll_powerdown;
   logic tx_digitalreset;
   logic rx_analogreset;
   logic rx_digitalreset;
   logic pll_drop;   // restart from power-down
   logic pll_up;     // pll out of power-down and locked
   logic all_ltd;

   assign all_ltd  = &lockedtodata;
   assign pll_up   = (tx_state != TX_PD) && pll_status.pll_locked;
   // lock loss only counts once the tx side was released
   assign pll_drop = reset_cmd.reset_all ||
                     (!pll_status.pll_locked && (tx_state inside {TX_REL, TX_READY}));

   // --------------------------------------
   // pll and tx side
   // --------------------------------------
   always_ff @(posedge mgmt_clk) begin
      if (!rst_n || pll_drop) begin
         tx_state        <= TX_PD;
         pd_cnt          <= '0;
         pll_powerdown   <= 1'b1;
         tx_digitalreset <= 1'b1;
         tx_ready        <= 1'b0;
      end else begin
         unique case (tx_state)
            TX_PD: begin
               pd_cnt <= pd_cnt + 1'b1;
               if (pd_cnt == xcvr_mgmt_pkg::PD_LAST) begin
                  pll_powerdown <= 1'b0;
                  tx_state      <= TX_LOCK;
               end
            end
            TX_LOCK: begin
               if (pll_status.pll_locked) begin
                  tx_digitalreset <= 1'b0;
                  tx_state        <= TX_REL;
               end
            end
            TX_REL: begin
               tx_ready <= 1'b1;   // one cycle after digital reset drops
               tx_state <= TX_READY;
            end
            TX_READY: tx_ready <= 1'b1;
         endcase
         // csr request, redo the tx release only
         if (reset_cmd.reset_tx_digital && (tx_state inside {TX_REL, TX_READY})) begin
            tx_digitalreset <= 1'b1;
            tx_ready        <= 1'b0;
            tx_state        <= TX_LOCK;
         end
      end
   end

   // --------------------------------------
   // rx side
   // --------------------------------------
   always_ff @(posedge mgmt_clk) begin
      if (!rst_n || pll_drop || !pll_up) begin
         rx_state        <= RX_ANALOG;
         ltd_cnt         <= '0;
         rx_analogreset  <= 1'b1;
         rx_digitalreset <= 1'b1;
         rx_ready        <= 1'b0;
      end else begin
         unique case (rx_state)
            RX_ANALOG: begin
               if (!pll_status.rx_oc_busy) begin   // wait out offset cancel
                  rx_analogreset <= 1'b0;
                  ltd_cnt        <= '0;
                  rx_state       <= RX_LTD;
               end
            end
            RX_LTD: begin
               if (!all_ltd) begin
                  ltd_cnt <= '0;   // need consecutive cycles
               end else if (ltd_cnt == xcvr_mgmt_pkg::LTD_LAST) begin
                  rx_digitalreset <= 1'b0;
                  rx_ready        <= 1'b1;
                  rx_state        <= RX_READY;
               end else begin
                  ltd_cnt <= ltd_cnt + 1'b1;
               end
            end
            RX_READY: begin
               if (!all_ltd) begin   // cdr lost lock, back to analog
                  rx_analogreset  <= 1'b1;
                  rx_digitalreset <= 1'b1;
                  rx_ready        <= 1'b0;
                  rx_state        <= RX_ANALOG;
               end else if (reset_cmd.reset_rx_digital) begin
                  rx_digitalreset <= 1'b1;
                  rx_ready        <= 1'b0;
                  ltd_cnt         <= '0;
                  rx_state        <= RX_LTD;
               end
            end
            default: rx_state <= RX_ANALOG;
         endcase
      end
   end

   assign phy_reset = '{pll_powerdown:   pll_powerdown,
                        tx_digitalreset: tx_digitalreset,
                        rx_analogreset:  rx_analogreset,
                        rx_digitalreset: rx_digitalreset};

endmodule

// ==== verilog/status_sync.sv ====
// --------------------------------------
// two-flop synchronizer for slow, level-type status
// multi-bit payloads are not coherent across bits
// --------------------------------------

`timescale 1ns/1ps

module status_sync #(
   parameter type payload_t = logic
) (
   input  logic     mgmt_clk,
   input  logic     rst_n,
   input  payload_t async_in,   // from phy, no clock relation
   output payload_t sync_out
);

   payload_t meta_q;   // first stage, may go metastable
   payload_t sync_q;

   always_ff @(posedge mgmt_clk) begin
      if (!rst_n) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= async_in;
         sync_q <= meta_q;
      end
   end

   assign sync_out = sync_q;   // 2 cycles latency

endmodule

// ==== verilog/xcvr_mgmt_pkg.sv ====
// --------------------------------------
// shared constants and types for the transceiver management side
// addresses are word addresses on the 8-bit mgmt bus
// delay counts are in mgmt_clk cycles and kept short for simulation
// lane count changes register bit positions in LANE_STATUS
// --------------------------------------

package xcvr_mgmt_pkg;

   // --------------------------------------
   // sizes
   // --------------------------------------
   localparam int LANES  = 4;
   localparam int LANE_W = 16;   // two 8-bit words per lane
   localparam int ADDR_W = 8;
   localparam int DATA_W = 32;

   // --------------------------------------
   // register map
   // --------------------------------------
   localparam logic [ADDR_W-1:0] ADDR_LANE_STATUS  = 8'h10;  // ro
   localparam logic [ADDR_W-1:0] ADDR_RESET_STATUS = 8'h11;  // ro
   localparam logic [ADDR_W-1:0] ADDR_RESET_CMD    = 8'h12;  // wo, pulses
   localparam logic [ADDR_W-1:0] ADDR_LOOPBACK     = 8'h13;  // rw
   localparam logic [ADDR_W-1:0] ADDR_TX_INVPOL    = 8'h20;  // rw
   localparam logic [ADDR_W-1:0] ADDR_RX_INVPOL    = 8'h21;  // rw

   // --------------------------------------
   // reset sequencer delays
   // --------------------------------------
   localparam int PLL_PD_CYCLES = 8;   // pll_powerdown hold time
   localparam int LTD_CYCLES    = 16;  // lockedtodata stable time
   localparam int PD_CNT_W      = $clog2(PLL_PD_CYCLES);
   localparam int LTD_CNT_W     = $clog2(LTD_CYCLES);
   localparam logic [PD_CNT_W-1:0]  PD_LAST  = PD_CNT_W'(PLL_PD_CYCLES - 1);
   localparam logic [LTD_CNT_W-1:0] LTD_LAST = LTD_CNT_W'(LTD_CYCLES - 1);

   // --------------------------------------
   // types
   // --------------------------------------
   typedef logic [LANES-1:0]             lane_mask_t;
   typedef logic [LANES-1:0][LANE_W-1:0] lane_data_t;

   typedef struct packed {
      logic pll_locked;
      logic rx_oc_busy;   // offset cancellation running
   } pll_status_t;

   typedef struct packed {
      lane_mask_t lockedtodata;
      lane_mask_t signaldetect;
   } lane_status_t;

   typedef struct packed {
      logic pll_powerdown;
      logic tx_digitalreset;
      logic rx_analogreset;
      logic rx_digitalreset;
   } phy_reset_t;

   typedef struct packed {
      logic reset_all;
      logic reset_tx_digital;
      logic reset_rx_digital;
   } reset_cmd_t;

   typedef struct packed {
      lane_mask_t loopback;
      lane_mask_t tx_invpol;
      lane_mask_t rx_invpol;
   } lane_ctrl_t;

endpackage

// ==== verilog/xcvr_mgmt_top.sv ====
// --------------------------------------
// transceiver management top, single mgmt_clk domain
// phy status is asynchronous and synchronized here, 2 cycles
// mgmt bus has no waitrequest, reads return one cycle later
// --------------------------------------

`timescale 1ns/1ps

module xcvr_mgmt_top (
   input  logic                              mgmt_clk,
   input  logic                              rst_n,
   // mgmt bus
   input  logic [xcvr_mgmt_pkg::ADDR_W-1:0]  mgmt_address,
   input  logic                              mgmt_read,
   input  logic                              mgmt_write,
   input  logic [xcvr_mgmt_pkg::DATA_W-1:0]  mgmt_writedata,
   output logic [xcvr_mgmt_pkg::DATA_W-1:0]  mgmt_readdata,
   // phy status and reset
   input  xcvr_mgmt_pkg::pll_status_t        pll_status,
   input  xcvr_mgmt_pkg::lane_status_t       lane_status,
   output xcvr_mgmt_pkg::phy_reset_t         phy_reset,
   output logic                              tx_ready,
   output logic                              rx_ready,
   // lane data
   input  xcvr_mgmt_pkg::lane_data_t         tx_parallel_data,
   output xcvr_mgmt_pkg::lane_data_t         phy_tx_data,
   input  xcvr_mgmt_pkg::lane_data_t         phy_rx_data,
   output xcvr_mgmt_pkg::lane_data_t         rx_parallel_data
);

   xcvr_mgmt_pkg::pll_status_t       pll_sync_q;    // synchronized pll status
   xcvr_mgmt_pkg::lane_status_t      lane_sync_q;   // synchronized lane status
   xcvr_mgmt_pkg::reset_cmd_t        reset_cmd;
   xcvr_mgmt_pkg::lane_mask_t        loopback;
   xcvr_mgmt_pkg::lane_mask_t        tx_invpol;
   xcvr_mgmt_pkg::lane_mask_t        rx_invpol;
   xcvr_mgmt_pkg::lane_ctrl_t        lane_ctrl;
   logic [xcvr_mgmt_pkg::DATA_W-1:0] readdata_common;
   logic [xcvr_mgmt_pkg::DATA_W-1:0] readdata_pcs;

   status_sync #(.payload_t(xcvr_mgmt_pkg::pll_status_t)) pll_sync (
      .mgmt_clk, .rst_n, .async_in(pll_status), .sync_out(pll_sync_q));

   status_sync #(.payload_t(xcvr_mgmt_pkg::lane_status_t)) lane_sync (
      .mgmt_clk, .rst_n, .async_in(lane_status), .sync_out(lane_sync_q));

   reset_sequencer reset_controller (
      .mgmt_clk, .rst_n,
      .pll_status   (pll_sync_q),
      .lockedtodata (lane_sync_q.lockedtodata),
      .reset_cmd, .phy_reset, .tx_ready, .rx_ready);

   csr_common csr (
      .mgmt_clk, .rst_n, .mgmt_address, .mgmt_read, .mgmt_write, .mgmt_writedata,
      .readdata    (readdata_common),
      .pll_status  (pll_sync_q),
      .lane_status (lane_sync_q),
      .phy_reset, .tx_ready, .rx_ready, .reset_cmd, .loopback);

   csr_pcs csr_pcs (
      .mgmt_clk, .rst_n, .mgmt_address, .mgmt_read, .mgmt_write, .mgmt_writedata,
      .readdata (readdata_pcs), .tx_invpol, .rx_invpol);

   // each block returns all ones outside its range
   assign mgmt_readdata = readdata_common & readdata_pcs;
   assign lane_ctrl     = '{loopback: loopback, tx_invpol: tx_invpol, rx_invpol: rx_invpol};

   lane_datapath datapath (
      .mgmt_clk, .rst_n, .lane_ctrl,
      .tx_parallel_data, .phy_tx_data, .phy_rx_data, .rx_parallel_data);

endmodule
